//--- tb/mem_cases.txt
# group master(0 cpu 1 fir 2 qsort 3 mm) we sel adr dat exp_rdata order
# sel adr dat exp_rdata in hex, exp_rdata checked on reads only, order is ack rank in group
0 0 1 f 00000010 11223344 00000000 0
1 0 0 f 00000010 00000000 11223344 0
2 1 1 f 00000020 aabbccdd 00000000 0
3 1 1 5 00000020 00550066 00000000 0
4 1 0 f 00000020 00000000 aa55cc66 0
5 1 1 f 00000100 f1f1f1f1 00000000 0
5 2 1 f 00000104 a2a2a2a2 00000000 1
5 3 1 f 00000108 3c3c3c3c 00000000 2
5 0 1 f 0000010c 0c0c0c0c 00000000 3
6 3 0 f 00000100 00000000 f1f1f1f1 2
6 1 0 f 00000104 00000000 a2a2a2a2 0
6 2 0 f 0000010c 00000000 0c0c0c0c 1
6 0 0 f 00000108 00000000 3c3c3c3c 3
7 1 0 f 00000010 00000000 11223344 0
7 2 1 a 00000020 12345678 00000000 1
7 3 0 f 00000020 00000000 12555666 2
7 0 0 f 00000104 00000000 a2a2a2a2 3
8 2 0 f 00000010 00000000 11223344 0
8 0 1 8 00000010 77000000 00000000 1
9 0 0 f 00000010 00000000 77223344 0

//--- src.f
+incdir+design
design/wb_pkg.sv
design/mem_pkg.sv
design/mem_cmd_if.sv
design/wb_arbiter.sv
design/cmd_fifo.sv
design/mem_ctrl.sv
design/mem_subsys_top.sv
tb/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/wb_pkg.sv
      - design/mem_pkg.sv
      - design/mem_cmd_if.sv
      - design/wb_arbiter.sv
      - design/cmd_fifo.sv
      - design/mem_ctrl.sv
      - design/mem_subsys_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_mem_subsys.sv

//--- tb/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_subsys;

  localparam int MAX_CASES = 64;
  localparam int NM = `MEM_NUM_MASTERS;

  logic clk;
  logic rst;

  // master side of the dut, indexed by master id
  logic         wbs_cyc  [NM];
  logic         wbs_stb  [NM];
  logic         wbs_we   [NM];
  wb_pkg::sel_t wbs_sel  [NM];
  wb_pkg::adr_t wbs_adr  [NM];
  wb_pkg::dat_t wbs_dat  [NM];
  logic         wbs_ack  [NM];
  wb_pkg::dat_t wbs_rdat [NM];

  // one entry per line of the cases file
  int               n_cases;
  int               c_grp [MAX_CASES];
  mem_pkg::master_e c_mst [MAX_CASES];
  logic             c_we  [MAX_CASES];
  wb_pkg::sel_t     c_sel [MAX_CASES];
  wb_pkg::adr_t     c_adr [MAX_CASES];
  wb_pkg::dat_t     c_dat [MAX_CASES];
  wb_pkg::dat_t     c_exp [MAX_CASES];
  int               c_ord [MAX_CASES];

  // request open on the bus
  logic busy    [NM];
  // ack seen, drop strobe on next edge
  logic acked   [NM];
  int   case_of [NM];
  // expected ack sequence of the running group
  mem_pkg::master_e exp_tag [NM];
  int   ack_idx;

  int cycle_cnt;
  int cycle_limit;

  mem_subsys_top u_mem_subsys_top (
    .clk       (clk),
    .rst       (rst),
    .wbs_cyc_i (wbs_cyc),
    .wbs_stb_i (wbs_stb),
    .wbs_we_i  (wbs_we),
    .wbs_sel_i (wbs_sel),
    .wbs_adr_i (wbs_adr),
    .wbs_dat_i (wbs_dat),
    .wbs_ack_o (wbs_ack),
    .wbs_dat_o (wbs_rdat)
  );

  // 40 ns period
  always #20 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_dat(input string name, input wb_pkg::dat_t got, input wb_pkg::dat_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_tag(input string name, input mem_pkg::master_e got,
                           input mem_pkg::master_e exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at %0t ns: %s got master %0d expected master %0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          rc;
    string       line;
    int          g;
    int          m;
    int          we;
    int          ord;
    logic [31:0] sel;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp_d;
    fd = $fopen("tb/mem_cases.txt", "r");
    if (fd == 0) begin
      report_failure("could not open tb/mem_cases.txt");
    end
    n_cases = 0;
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      // comment and blank lines give fewer than 8 fields
      if (rc > 0) begin
        rc = $sscanf(line, "%d %d %d %h %h %h %h %d", g, m, we, sel, adr, dat, exp_d, ord);
        if (rc == 8 && n_cases < MAX_CASES) begin
          c_grp[n_cases] = g;
          c_mst[n_cases] = mem_pkg::master_e'(m);
          c_we[n_cases]  = (we != 0);
          c_sel[n_cases] = wb_pkg::sel_t'(sel);
          c_adr[n_cases] = wb_pkg::adr_t'(adr);
          c_dat[n_cases] = wb_pkg::dat_t'(dat);
          c_exp[n_cases] = wb_pkg::dat_t'(exp_d);
          c_ord[n_cases] = ord;
          n_cases++;
        end
      end
    end
    $fclose(fd);
    if (n_cases == 0) begin
      report_failure("no cases found in tb/mem_cases.txt");
    end
  endtask

  // all lines of a group start on one edge
  task automatic run_group(input int first, input int last);
    int m;
    int dropped;
    ack_idx = 0;
    @(posedge clk);
    for (int i = first; i < last; i++) begin
      m = int'(c_mst[i]);
      exp_tag[c_ord[i]] = c_mst[i];
      case_of[m] = i;
      busy[m] = 1'b1;
      wbs_cyc[m] <= 1'b1;
      wbs_stb[m] <= 1'b1;
      wbs_we[m]  <= c_we[i];
      wbs_sel[m] <= c_sel[i];
      wbs_adr[m] <= c_adr[i];
      wbs_dat[m] <= c_dat[i];
    end
    dropped = 0;
    while (dropped < last - first) begin
      @(posedge clk);
      // edge that ends the ack cycle
      for (int k = 0; k < NM; k++) begin
        if (acked[k]) begin
          wbs_cyc[k] <= 1'b0;
          wbs_stb[k] <= 1'b0;
          acked[k] = 1'b0;
          busy[k]  = 1'b0;
          dropped++;
        end
      end
    end
  endtask

  // acks sampled mid-cycle, away from the edge
  always @(negedge clk) begin
    int hits;
    hits = 0;
    for (int k = 0; k < NM; k++) begin
      if (wbs_ack[k] === 1'b1) begin
        hits++;
        if (!busy[k] || acked[k]) begin
          report_failure($sformatf("ack to an idle master (master %0d)", k));
        end
        check_tag("wbs_ack_o order", mem_pkg::master_e'(k), exp_tag[ack_idx]);
        // write data on dat_o is don't care
        if (!c_we[case_of[k]]) begin
          check_dat($sformatf("wbs_dat_o[%0d]", k), wbs_rdat[k], c_exp[case_of[k]]);
        end
        acked[k] = 1'b1;
        ack_idx++;
      end
    end
    if (hits > 1) begin
      report_failure("two acks in one cycle");
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      report_failure("timeout: not all acks arrived");
    end
  end

  initial begin
    int i;
    int first;
    int gap;
    clk = 1'b0;
    rst = 1'b0;
    for (int k = 0; k < NM; k++) begin
      wbs_cyc[k] = 1'b0;
      wbs_stb[k] = 1'b0;
      wbs_we[k]  = 1'b0;
      wbs_sel[k] = '0;
      wbs_adr[k] = '0;
      wbs_dat[k] = '0;
      busy[k]    = 1'b0;
      acked[k]   = 1'b0;
      case_of[k] = 0;
      exp_tag[k] = mem_pkg::M_CPU;
    end
    ack_idx     = 0;
    cycle_cnt   = 0;
    cycle_limit = 16;
    void'($urandom(32'ha20f4f4a));
    load_cases();
    cycle_limit = 16 + 40 * n_cases;
    // masters idle through reset, any ack is an error
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    i = 0;
    while (i < n_cases) begin
      gap = $urandom % 4;
      repeat (gap) @(posedge clk);
      first = i;
      while (i < n_cases && c_grp[i] == c_grp[first]) begin
        i++;
      end
      run_group(first, i);
    end
    // late or repeated acks would show here
    repeat (4) @(posedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_subsys_top (
  input  wire logic    clk,
  input  wire logic    rst,
  // per-master wishbone ports, indexed by master id
  input  wire logic    wbs_cyc_i [`MEM_NUM_MASTERS],
  input  wire logic    wbs_stb_i [`MEM_NUM_MASTERS],
  input  wire logic    wbs_we_i  [`MEM_NUM_MASTERS],
  input  wb_pkg::sel_t wbs_sel_i [`MEM_NUM_MASTERS],
  input  wb_pkg::adr_t wbs_adr_i [`MEM_NUM_MASTERS],
  input  wb_pkg::dat_t wbs_dat_i [`MEM_NUM_MASTERS],
  output logic         wbs_ack_o [`MEM_NUM_MASTERS],
  output wb_pkg::dat_t wbs_dat_o [`MEM_NUM_MASTERS]
);

  // arbiter to queue
  mem_cmd_if push_if ();
  // queue to controller
  mem_cmd_if pop_if ();

  // response path back to the arbiter
  logic             resp_valid;
  mem_pkg::master_e resp_tag;
  wb_pkg::dat_t     resp_dat;

  wb_arbiter u_wb_arbiter (
    .clk          (clk),
    .rst          (rst),
    .wbs_cyc_i    (wbs_cyc_i),
    .wbs_stb_i    (wbs_stb_i),
    .wbs_we_i     (wbs_we_i),
    .wbs_sel_i    (wbs_sel_i),
    .wbs_adr_i    (wbs_adr_i),
    .wbs_dat_i    (wbs_dat_i),
    .wbs_ack_o    (wbs_ack_o),
    .wbs_dat_o    (wbs_dat_o),
    .cmd_o        (push_if),
    .resp_valid_i (resp_valid),
    .resp_tag_i   (resp_tag),
    .resp_dat_i   (resp_dat)
  );

  // buffers granted commands
  cmd_fifo u_cmd_fifo (
    .clk    (clk),
    .rst    (rst),
    .push_i (push_if),
    .pop_o  (pop_if)
  );

  // executes in order against the word array
  mem_ctrl u_mem_ctrl (
    .clk          (clk),
    .rst          (rst),
    .cmd_i        (pop_if),
    .resp_valid_o (resp_valid),
    .resp_tag_o   (resp_tag),
    .resp_dat_o   (resp_dat)
  );

endmodule

`default_nettype wire

//--- design/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_ctrl (
  input  wire logic        clk,
  input  wire logic        rst,
  mem_cmd_if.dst           cmd_i,
  output logic             resp_valid_o,
  output mem_pkg::master_e resp_tag_o,
  output wb_pkg::dat_t     resp_dat_o
);

  // read latency is the longer one
  localparam int unsigned CNT_W = $clog2(`MEM_READ_LAT);

  // stands in for the sdram device
  wb_pkg::dat_t mem [2**`MEM_INDEX_W];

  mem_pkg::ctrl_state_e state_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 accept;
  mem_pkg::index_t      cmd_idx;
  // latched command
  mem_pkg::index_t      idx_q;
  mem_pkg::master_e     tag_q;
  wb_pkg::dat_t         rd_dat_q;

  // one command at a time
  assign cmd_i.ready = (state_q == mem_pkg::IDLE);
  assign accept      = cmd_i.valid && cmd_i.ready;
  // byte address to word index
  assign cmd_idx     = cmd_i.adr[`MEM_INDEX_W+1:2];

  // busy lasts latency minus one cycles, then one respond cycle
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= mem_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        mem_pkg::IDLE: begin
          if (accept) begin
            state_q <= mem_pkg::BUSY;
            cnt_q   <= cmd_i.we ? CNT_W'(`MEM_WRITE_LAT - 2) : CNT_W'(`MEM_READ_LAT - 2);
          end
        end
        mem_pkg::BUSY: begin
          if (cnt_q == '0) begin
            state_q <= mem_pkg::RESPOND;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        mem_pkg::RESPOND: state_q <= mem_pkg::IDLE;
        default:          state_q <= mem_pkg::IDLE;
      endcase
    end
  end

  // write lanes at accept, unselected bytes keep old value
  always_ff @(posedge clk) begin
    if (accept && cmd_i.we) begin
      for (int b = 0; b < `MEM_SEL_W; b++) begin
        if (cmd_i.sel[b]) begin
          mem[cmd_idx][b*8 +: 8] <= cmd_i.dat[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      idx_q <= cmd_idx;
      tag_q <= cmd_i.tag;
    end
    // sample on the way into respond
    if (state_q == mem_pkg::BUSY && cnt_q == '0) begin
      rd_dat_q <= mem[idx_q];
    end
  end

  // single cycle pulse, no back-pressure
  assign resp_valid_o = (state_q == mem_pkg::RESPOND);
  assign resp_tag_o   = tag_q;
  assign resp_dat_o   = rd_dat_q;

endmodule

`default_nettype wire

//--- design/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module cmd_fifo (
  input  wire logic clk,
  input  wire logic rst,
  mem_cmd_if.dst    push_i,
  mem_cmd_if.src    pop_o
);

  localparam int unsigned DEPTH = `MEM_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  // one extra bit so full is representable
  localparam int unsigned CNT_W = PTR_W + 1;

  // entry storage, payload only
  logic             we_mem  [DEPTH];
  wb_pkg::sel_t     sel_mem [DEPTH];
  wb_pkg::adr_t     adr_mem [DEPTH];
  wb_pkg::dat_t     dat_mem [DEPTH];
  mem_pkg::master_e tag_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // full stalls the arbiter
  assign push_i.ready = (count_q != CNT_W'(DEPTH));
  assign pop_o.valid  = (count_q != '0);

  assign push = push_i.valid && push_i.ready;
  assign pop  = pop_o.valid && pop_o.ready;

  // head entry straight from storage
  assign pop_o.we  = we_mem[rd_ptr_q];
  assign pop_o.sel = sel_mem[rd_ptr_q];
  assign pop_o.adr = adr_mem[rd_ptr_q];
  assign pop_o.dat = dat_mem[rd_ptr_q];
  assign pop_o.tag = tag_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      we_mem[wr_ptr_q]  <= push_i.we;
      sel_mem[wr_ptr_q] <= push_i.sel;
      adr_mem[wr_ptr_q] <= push_i.adr;
      dat_mem[wr_ptr_q] <= push_i.dat;
      tag_mem[wr_ptr_q] <= push_i.tag;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module wb_arbiter (
  input  wire logic              clk,
  input  wire logic              rst,
  // master request side, indexed by master id
  input  wire logic              wbs_cyc_i [`MEM_NUM_MASTERS],
  input  wire logic              wbs_stb_i [`MEM_NUM_MASTERS],
  input  wire logic              wbs_we_i  [`MEM_NUM_MASTERS],
  input  wb_pkg::sel_t           wbs_sel_i [`MEM_NUM_MASTERS],
  input  wb_pkg::adr_t           wbs_adr_i [`MEM_NUM_MASTERS],
  input  wb_pkg::dat_t           wbs_dat_i [`MEM_NUM_MASTERS],
  output logic                   wbs_ack_o [`MEM_NUM_MASTERS],
  output wb_pkg::dat_t           wbs_dat_o [`MEM_NUM_MASTERS],
  // command push into the queue
  mem_cmd_if.src                 cmd_o,
  // response from the controller
  input  wire logic              resp_valid_i,
  input  mem_pkg::master_e       resp_tag_i,
  input  wb_pkg::dat_t           resp_dat_i
);

  // one flag per master, set on push, cleared on response
  logic [`MEM_NUM_MASTERS-1:0] pend_q;
  // masters asking and not yet issued
  logic [`MEM_NUM_MASTERS-1:0] req;
  mem_pkg::master_e            grant_tag;
  logic                        push;

  // a held strobe only counts once
  always_comb begin
    for (int m = 0; m < `MEM_NUM_MASTERS; m++) begin
      req[m] = wbs_cyc_i[m] && wbs_stb_i[m] && !pend_q[m];
    end
  end

  // fixed priority, fir first, cpu last
  always_comb begin
    grant_tag = mem_pkg::M_CPU;
    if (req[mem_pkg::M_FIR]) begin
      grant_tag = mem_pkg::M_FIR;
    end else if (req[mem_pkg::M_QSORT]) begin
      grant_tag = mem_pkg::M_QSORT;
    end else if (req[mem_pkg::M_MM]) begin
      grant_tag = mem_pkg::M_MM;
    end
  end

  // choice is redone every cycle until the queue takes it
  assign cmd_o.valid = |req;
  assign cmd_o.we    = wbs_we_i[grant_tag];
  assign cmd_o.sel   = wbs_sel_i[grant_tag];
  assign cmd_o.adr   = wbs_adr_i[grant_tag];
  assign cmd_o.dat   = wbs_dat_i[grant_tag];
  assign cmd_o.tag   = grant_tag;

  assign push = cmd_o.valid && cmd_o.ready;

  // granted master never has a response due in the same cycle
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pend_q <= '0;
    end else begin
      if (push) begin
        pend_q[grant_tag] <= 1'b1;
      end
      if (resp_valid_i) begin
        pend_q[resp_tag_i] <= 1'b0;
      end
    end
  end

  // ack routed by tag, read data broadcast
  always_comb begin
    for (int m = 0; m < `MEM_NUM_MASTERS; m++) begin
      wbs_ack_o[m] = resp_valid_i && (resp_tag_i == mem_pkg::master_e'(m));
      wbs_dat_o[m] = resp_dat_i;
    end
  end

endmodule

`default_nettype wire

//--- design/mem_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// tagged command, valid/ready handshake
interface mem_cmd_if;

  logic              valid;
  logic              ready;
  logic              we;
  wb_pkg::sel_t      sel;
  wb_pkg::adr_t      adr;
  wb_pkg::dat_t      dat;
  mem_pkg::master_e  tag;

  // producer side, holds valid and payload until ready
  modport src (output valid, we, sel, adr, dat, tag, input ready);

  // consumer side
  modport dst (input valid, we, sel, adr, dat, tag, output ready);

endinterface

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

  // master id, also the command and response tag
  typedef enum logic [1:0] {
    M_CPU   = 2'd0,
    M_FIR   = 2'd1,
    M_QSORT = 2'd2,
    M_MM    = 2'd3
  } master_e;

  // word index, from byte address bits [9:2]
  typedef logic [`MEM_INDEX_W-1:0] index_t;

  // controller fsm
  typedef enum logic [1:0] {IDLE, BUSY, RESPOND} ctrl_state_e;

endpackage

`default_nettype wire

//--- design/wb_pkg.sv
`default_nettype none

`include "mem_params.svh"

package wb_pkg;

  // one bus data word
  typedef logic [`MEM_DATA_W-1:0] dat_t;
  // byte address as seen by the masters
  typedef logic [`MEM_ADDR_W-1:0] adr_t;
  // byte lane enables
  typedef logic [`MEM_SEL_W-1:0] sel_t;

endpackage

`default_nettype wire

//--- design/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// wishbone bus widths
`define MEM_DATA_W 32
`define MEM_ADDR_W 32
`define MEM_SEL_W 4

// fir, qsort, mm and cpu
`define MEM_NUM_MASTERS 4

// command queue entries, power of two
`define MEM_FIFO_DEPTH 2

// word index bits, 256 words
`define MEM_INDEX_W 8

// accept to response pulse, in cycles, both at least 2
`define MEM_READ_LAT 3
`define MEM_WRITE_LAT 2

`endif
